//--- mmu_pkg.sv
// shared Sv32 constants, types and the leaf permission rule, imported by every MMU block
package mmu_pkg;

    localparam int PA_WIDTH    = 34;
    localparam int VPN_WIDTH   = 10;
    localparam int PPN_WIDTH   = 22;
    localparam int PGSIZE_BITS = 12;
    localparam int SV32_LEVELS = 2;
    localparam int TLB_ENTRIES = 8;
    localparam logic MODE_SV32 = 1'b1;  // satp.mode value for Sv32

    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        S_MODE = 2'b01,
        M_MODE = 2'b11
    } priv_t;

    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE,
        INSTRUCTION
    } access_t;

    typedef enum logic [1:0] {
        IDLE,
        WALK,
        DONE
    } pw_state_t;

    typedef struct packed {
        logic [1:0] reserved;  // rsw, ignored
        logic       dirty;
        logic       accessed;
        logic       global;
        logic       user;
        logic       executable;
        logic       writable;
        logic       readable;
        logic       valid;
    } pte_perms_t;

    typedef struct packed {
        logic [PPN_WIDTH-1:0] ppn;
        pte_perms_t           perms;
    } pte_t;

    typedef struct packed {
        logic                   valid;
        logic [2*VPN_WIDTH-1:0] vpn;
        logic [PPN_WIDTH-1:0]   ppn;
        pte_perms_t             perms;
        logic                   superpage;  // 4 MiB leaf found at level 1
    } tlb_entry_t;

    // true when the leaf permissions forbid the access
    function automatic logic pte_fault(input pte_perms_t perms, input access_t acc,
                                       input priv_t priv, input logic sum);
        logic f;
        case (acc)
            INSTRUCTION: f = ~perms.executable;
            STORE:       f = ~perms.writable;
            LOAD:        f = ~perms.readable;
            default:     f = 1'b0;
        endcase
        if (perms.user && priv == S_MODE && !sum)
            f = 1'b1;  // supervisor touching user page
        if (!perms.user && priv == U_MODE)
            f = 1'b1;
        return f;
    endfunction

endpackage

//--- mem_bus_if.sv
// generic memory bus and TLB refill channel, instantiated inside mmu_top between its blocks
`timescale 1ns/1ps

interface mem_bus_if import mmu_pkg::*; ();
    logic                ren;
    logic                wen;
    logic [PA_WIDTH-1:0] addr;
    logic [31:0]         wdata;
    logic [31:0]         rdata;
    logic                busy;  // high while a request is pending

    // requester side
    modport cpu (output ren, wen, addr, wdata, input rdata, busy);
    // responder side
    modport generic_bus (input ren, wen, addr, wdata, output rdata, busy);
endinterface

interface refill_if import mmu_pkg::*; ();
    logic                   req;
    logic [2*VPN_WIDTH-1:0] vpn;
    access_t                access;
    logic                   done;   // one-cycle pulse from the walker
    logic                   fault;
    tlb_entry_t             entry;

    modport requester (output req, vpn, access, input done, fault, entry);
    modport walker (input req, vpn, access, output done, fault, entry);
endinterface

//--- tlb.sv
// fully associative Sv32 TLB, used as both the instruction and the data TLB in mmu_top
`timescale 1ns/1ps

module tlb import mmu_pkg::*; (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                req,
    input  access_t             access,
    input  logic [31:0]         vaddr,
    input  logic                trans_on,
    input  priv_t               priv,
    input  logic                sum,
    input  logic                flush,
    output logic [PA_WIDTH-1:0] paddr,
    output logic                hit_done,
    output logic                fault,
    refill_if.requester         refill
);

    tlb_entry_t                     entries [TLB_ENTRIES];
    logic [$clog2(TLB_ENTRIES)-1:0] rr_ptr;  // next victim slot
    logic [2*VPN_WIDTH-1:0]         vpn;
    tlb_entry_t                     hit_entry;
    logic                           hit;
    logic                           hit_fault;
    logic                           miss;
    logic                           req_q;
    logic                           fault_q;  // walk ended in a fault

    assign vpn = vaddr[31:PGSIZE_BITS];

    // lookup, lowest matching slot wins
    always_comb begin
        hit       = 1'b0;
        hit_entry = entries[0];
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entries[i].valid &&
                entries[i].vpn[2*VPN_WIDTH-1:VPN_WIDTH] == vpn[2*VPN_WIDTH-1:VPN_WIDTH] &&
                (entries[i].superpage ||
                 entries[i].vpn[VPN_WIDTH-1:0] == vpn[VPN_WIDTH-1:0])) begin
                hit       = 1'b1;
                hit_entry = entries[i];
            end
        end
    end

    always_comb begin
        if (!trans_on)
            paddr = {{(PA_WIDTH-32){1'b0}}, vaddr};  // bare: zero extend
        else if (hit_entry.superpage)
            paddr = {hit_entry.ppn[PPN_WIDTH-1:VPN_WIDTH], vaddr[VPN_WIDTH+PGSIZE_BITS-1:0]};
        else
            paddr = {hit_entry.ppn, vaddr[PGSIZE_BITS-1:0]};
    end

    assign hit_fault = pte_fault(hit_entry.perms, access, priv, sum);
    assign hit_done  = req && (!trans_on || (hit && !hit_fault));
    assign fault     = (req && trans_on && hit && hit_fault) || fault_q;
    assign miss      = req && trans_on && !hit && !fault_q;

    assign refill.req    = req_q;
    assign refill.vpn    = vpn;
    assign refill.access = access;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req_q   <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            fault_q <= refill.done && refill.fault;
            if (refill.done)
                req_q <= 1'b0;
            else if (miss)
                req_q <= 1'b1;  // held until the walker answers
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rr_ptr <= '0;
            for (int i = 0; i < TLB_ENTRIES; i++)
                entries[i].valid <= 1'b0;
        end else begin
            if (refill.done && !refill.fault) begin
                entries[rr_ptr] <= refill.entry;
                rr_ptr          <= rr_ptr + 1'b1;
            end
            if (flush) begin
                for (int i = 0; i < TLB_ENTRIES; i++)
                    entries[i].valid <= 1'b0;
            end
        end
    end

endmodule

//--- page_walker.sv
// Sv32 page table walker shared by both TLBs in mmu_top, reads PTEs through the arbiter
`timescale 1ns/1ps

module page_walker import mmu_pkg::*; (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [PPN_WIDTH-1:0] satp_ppn,
    input  priv_t                priv,
    input  logic                 sum,
    refill_if.walker             irefill,
    refill_if.walker             drefill,
    mem_bus_if.cpu               mem
);

    pw_state_t              state;
    logic                   owner_d;  // 1 when serving the data TLB
    logic [2:0]             level;    // wide enough for deeper modes
    logic [2*VPN_WIDTH-1:0] vpn_q;
    logic [2*VPN_WIDTH-1:0] sel_vpn;
    access_t                access_q;
    access_t                sel_access;
    logic [PA_WIDTH-1:0]    pte_addr;
    tlb_entry_t             entry_q;
    logic                   fault_q;
    pte_t                   pte;
    logic                   pte_bad;
    logic                   pte_leaf;
    logic                   super_misalign;

    // data TLB has priority
    assign sel_vpn    = drefill.req ? drefill.vpn : irefill.vpn;
    assign sel_access = drefill.req ? drefill.access : irefill.access;

    assign pte            = pte_t'(mem.rdata);
    assign pte_bad        = !pte.perms.valid || (!pte.perms.readable && pte.perms.writable);
    assign pte_leaf       = pte.perms.readable || pte.perms.executable;
    assign super_misalign = (level != '0) && (pte.ppn[VPN_WIDTH-1:0] != '0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= IDLE;
            owner_d <= 1'b0;
            level   <= '0;
            fault_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    fault_q <= 1'b0;
                    if (drefill.req || irefill.req) begin
                        state   <= WALK;
                        owner_d <= drefill.req;
                        level   <= 3'(SV32_LEVELS - 1);
                    end
                end
                WALK: begin
                    if (!mem.busy) begin
                        if (pte_bad || (!pte_leaf && level == '0)) begin
                            fault_q <= 1'b1;  // invalid or pointer at last level
                            state   <= DONE;
                        end else if (pte_leaf) begin
                            fault_q <= super_misalign ||
                                       pte_fault(pte.perms, access_q, priv, sum);
                            state   <= DONE;
                        end else begin
                            level <= level - 1'b1;  // descend one level
                        end
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // walk payload
    always_ff @(posedge CLK) begin
        if (state == IDLE) begin
            vpn_q    <= sel_vpn;
            access_q <= sel_access;
            pte_addr <= {satp_ppn, sel_vpn[2*VPN_WIDTH-1:VPN_WIDTH], 2'b00};
        end else if (state == WALK && !mem.busy) begin
            pte_addr          <= {pte.ppn, vpn_q[VPN_WIDTH-1:0], 2'b00};
            entry_q.valid     <= 1'b1;
            entry_q.vpn       <= vpn_q;
            entry_q.ppn       <= pte.ppn;
            entry_q.perms     <= pte.perms;
            entry_q.superpage <= (level != '0);
        end
    end

    assign mem.ren   = (state == WALK);
    assign mem.wen   = 1'b0;  // no A/D updates
    assign mem.addr  = pte_addr;
    assign mem.wdata = '0;

    assign drefill.done  = (state == DONE) && owner_d;
    assign irefill.done  = (state == DONE) && !owner_d;
    assign drefill.fault = fault_q;
    assign irefill.fault = fault_q;
    assign drefill.entry = entry_q;
    assign irefill.entry = entry_q;

endmodule

//--- mem_arbiter.sv
// fixed priority arbiter in mmu_top, puts the walker or the data path on the memory port
`timescale 1ns/1ps

module mem_arbiter import mmu_pkg::*; (
    input  logic                CLK,
    input  logic                nRST,
    mem_bus_if.generic_bus      walk,
    mem_bus_if.generic_bus      data,
    output logic                mem_ren,
    output logic                mem_wen,
    output logic [PA_WIDTH-1:0] mem_addr,
    output logic [31:0]         mem_wdata,
    input  logic [31:0]         mem_rdata,
    input  logic                mem_busy
);

    logic walk_req;
    logic data_req;
    logic sel_walk;
    logic active;
    logic owner_q;   // 1 = walker owns the port
    logic locked_q;  // transfer in flight

    assign walk_req = walk.ren || walk.wen;
    assign data_req = data.ren || data.wen;
    assign sel_walk = locked_q ? owner_q : (walk_req || !data_req);
    assign active   = sel_walk ? walk_req : data_req;

    assign mem_ren   = sel_walk ? walk.ren : data.ren;
    assign mem_wen   = sel_walk ? walk.wen : data.wen;
    assign mem_addr  = sel_walk ? walk.addr : data.addr;
    assign mem_wdata = sel_walk ? walk.wdata : data.wdata;

    assign walk.rdata = mem_rdata;
    assign data.rdata = mem_rdata;
    assign walk.busy  = sel_walk ? mem_busy : 1'b1;  // loser just waits
    assign data.busy  = sel_walk ? 1'b1 : mem_busy;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            owner_q  <= 1'b0;
            locked_q <= 1'b0;
        end else if (active && mem_busy) begin
            owner_q  <= sel_walk;
            locked_q <= 1'b1;
        end else if (active) begin
            locked_q <= 1'b0;  // completed
        end
    end

endmodule

//--- mmu_top.sv
// Sv32 translation unit top, joins both TLBs, the walker, the arbiter and the data access path
`timescale 1ns/1ps

module mmu_top import mmu_pkg::*; (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 satp_mode,
    input  logic [PPN_WIDTH-1:0] satp_ppn,
    input  priv_t                priv,
    input  logic                 sum,
    input  logic                 sfence,
    input  logic                 i_ren,
    input  logic [31:0]          i_vaddr,
    output logic                 i_busy,
    output logic [PA_WIDTH-1:0]  i_paddr,
    output logic                 i_fault,
    input  logic                 d_ren,
    input  logic                 d_wen,
    input  logic [31:0]          d_vaddr,
    input  logic [31:0]          d_wdata,
    output logic [31:0]          d_rdata,
    output logic                 d_busy,
    output logic                 d_fault_load,
    output logic                 d_fault_store,
    output logic                 mem_ren,
    output logic                 mem_wen,
    output logic [PA_WIDTH-1:0]  mem_addr,
    output logic [31:0]          mem_wdata,
    input  logic [31:0]          mem_rdata,
    input  logic                 mem_busy
);

    typedef enum logic {D_XLATE, D_ACCESS} dpath_state_t;

    dpath_state_t        dstate;
    logic                trans_on;
    logic                itlb_done;
    logic                dtlb_done;
    logic                dtlb_fault;
    logic                d_req;
    access_t             d_access;
    logic [PA_WIDTH-1:0] d_paddr;
    logic [PA_WIDTH-1:0] d_paddr_q;

    mem_bus_if walk_bus ();
    mem_bus_if data_bus ();
    refill_if  irefill ();
    refill_if  drefill ();

    // only S and U mode translate
    assign trans_on = (satp_mode == MODE_SV32) && (priv == S_MODE || priv == U_MODE);

    assign d_req    = d_ren || d_wen;
    assign d_access = d_wen ? STORE : (d_ren ? LOAD : NONE);

    tlb itlb_i (
        .CLK(CLK), .nRST(nRST), .req(i_ren), .access(INSTRUCTION), .vaddr(i_vaddr),
        .trans_on(trans_on), .priv(priv), .sum(sum), .flush(sfence),
        .paddr(i_paddr), .hit_done(itlb_done), .fault(i_fault), .refill(irefill)
    );

    tlb dtlb_i (
        .CLK(CLK), .nRST(nRST), .req(d_req && dstate == D_XLATE), .access(d_access),
        .vaddr(d_vaddr), .trans_on(trans_on), .priv(priv), .sum(sum), .flush(sfence),
        .paddr(d_paddr), .hit_done(dtlb_done), .fault(dtlb_fault), .refill(drefill)
    );

    page_walker page_walker_i (
        .CLK(CLK), .nRST(nRST), .satp_ppn(satp_ppn), .priv(priv), .sum(sum),
        .irefill(irefill), .drefill(drefill), .mem(walk_bus)
    );

    mem_arbiter mem_arbiter_i (
        .CLK(CLK), .nRST(nRST), .walk(walk_bus), .data(data_bus),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata), .mem_busy(mem_busy)
    );

    assign i_busy = i_ren && !itlb_done && !i_fault;

    // data path: translate, then one access on data_bus
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            dstate <= D_XLATE;
        else if (dstate == D_XLATE && dtlb_done)
            dstate <= D_ACCESS;
        else if (dstate == D_ACCESS && !data_bus.busy)
            dstate <= D_XLATE;
    end

    always_ff @(posedge CLK) begin
        if (dtlb_done)
            d_paddr_q <= d_paddr;
    end

    assign data_bus.ren   = (dstate == D_ACCESS) && d_ren;
    assign data_bus.wen   = (dstate == D_ACCESS) && d_wen;
    assign data_bus.addr  = d_paddr_q;
    assign data_bus.wdata = d_wdata;

    assign d_rdata       = data_bus.rdata;
    assign d_busy        = d_req && !dtlb_fault && !(dstate == D_ACCESS && !data_bus.busy);
    assign d_fault_load  = dtlb_fault && d_access == LOAD;
    assign d_fault_store = dtlb_fault && d_access == STORE;

endmodule

//--- tb_mmu.sv
// testbench that runs mmu_top against a prebuilt Sv32 page table model and is built from tb.f by the Makefile
`timescale 1ns/1ps

module tb_mmu import mmu_pkg::*; ();

    localparam int                   WAIT_LIMIT = 300;  // cycles per handshake
    localparam logic [PPN_WIDTH-1:0] ROOT_PPN   = 22'h100;
    localparam logic [PPN_WIDTH-1:0] L0_PPN     = 22'h101;

    logic                 CLK;
    logic                 nRST;
    logic                 satp_mode;
    logic [PPN_WIDTH-1:0] satp_ppn;
    priv_t                priv;
    logic                 sum;
    logic                 sfence;
    logic                 i_ren;
    logic [31:0]          i_vaddr;
    logic                 i_busy;
    logic [PA_WIDTH-1:0]  i_paddr;
    logic                 i_fault;
    logic                 d_ren;
    logic                 d_wen;
    logic [31:0]          d_vaddr;
    logic [31:0]          d_wdata;
    logic [31:0]          d_rdata;
    logic                 d_busy;
    logic                 d_fault_load;
    logic                 d_fault_store;
    logic                 mem_ren;
    logic                 mem_wen;
    logic [PA_WIDTH-1:0]  mem_addr;
    logic [31:0]          mem_wdata;
    logic [31:0]          mem_rdata = 32'h0;
    logic                 mem_busy  = 1'b0;

    logic [31:0]          mem [logic [31:0]];  // word indexed
    logic [15:0]          lfsr      = 16'd66;
    logic [1:0]           stall     = 2'd0;
    logic                 in_xfer   = 1'b0;
    int                   pte_reads = 0;
    int                   reads_mark;
    int                   errors;
    int                   err_mark;
    int                   tests;
    int                   failed;

    // expected results set together with each request
    logic [PA_WIDTH-1:0]  exp_i_paddr;
    logic                 exp_i_fault;
    logic [PA_WIDTH-1:0]  exp_d_paddr;
    logic                 exp_d_fault;
    logic [31:0]          exp_d_rdata;
    logic [31:0]          exp_d_wdata;

    mmu_top mmu_top_i (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // taps 16 14 13 11
    endfunction

    function automatic logic [31:0] read_word(input logic [PA_WIDTH-1:0] a);
        if (mem.exists(a[33:2]))
            return mem[a[33:2]];
        return {a[17:2], a[33:18]} ^ 32'h5AC3_3CA5;  // fill from every address bit
    endfunction

    function automatic logic is_table_addr(input logic [PA_WIDTH-1:0] a);
        return a[33:12] == ROOT_PPN || a[33:12] == L0_PPN;
    endfunction

    // Sv32 reference walk over the model memory
    function automatic void ref_translate(input logic [31:0] va, input access_t acc,
                                          output logic [PA_WIDTH-1:0] pa, output logic flt);
        logic [PA_WIDTH-1:0] a;
        logic [31:0]         pte;
        logic                allowed;
        pa  = {2'b00, va};
        flt = 1'b0;
        if (!satp_mode || !(priv == S_MODE || priv == U_MODE))
            return;
        a = {satp_ppn, va[31:22], 2'b00};
        for (int lvl = 1; lvl >= 0; lvl--) begin
            pte = read_word(a);
            if (!pte[0] || (!pte[1] && pte[2])) begin
                flt = 1'b1;
                return;
            end
            if (pte[1] || pte[3]) begin
                case (acc)
                    INSTRUCTION: allowed = pte[3];
                    STORE:       allowed = pte[2];
                    default:     allowed = pte[1];
                endcase
                flt = !allowed || (lvl == 1 && pte[19:10] != 10'd0);
                if (pte[4] && priv == S_MODE && !sum)
                    flt = 1'b1;
                if (!pte[4] && priv == U_MODE)
                    flt = 1'b1;
                pa = (lvl == 1) ? {pte[31:20], va[21:0]} : {pte[31:10], va[11:0]};
                return;
            end
            a = {pte[31:10], va[21:12], 2'b00};
        end
        flt = 1'b1;  // pointer at level 0
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR %0t ns: %s", $time, msg);
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s", what);
        $display("*** FAILED ***");
        $finish;
    endtask

    // memory port model with random stalls of 0 to 3 cycles
    always @(posedge CLK) begin
        #2;
        if (mem_ren || mem_wen) begin
            if (!in_xfer) begin
                in_xfer = 1'b1;
                for (int b = 0; b < 2; b++) begin
                    lfsr  = lfsr_next(lfsr);
                    stall = {stall[0], lfsr[0]};
                end
            end
            if (stall == 2'd0) begin
                mem_busy  = 1'b0;
                mem_rdata = read_word(mem_addr);
                if (mem_wen)
                    mem[mem_addr[33:2]] = mem_wdata;
                else if (is_table_addr(mem_addr))
                    pte_reads++;
                in_xfer = 1'b0;
            end else begin
                mem_busy = 1'b1;
                stall    = stall - 2'd1;
            end
        end else begin
            mem_busy = 1'b0;
        end
    end

    fetch_paddr_ok: assert property (@(posedge CLK) disable iff (!nRST)
        i_ren && !i_busy && !i_fault |-> i_paddr == exp_i_paddr && !exp_i_fault)
        else report_error("fetch finished with a wrong paddr or without its fault");
    fetch_fault_ok: assert property (@(posedge CLK) disable iff (!nRST)
        i_fault |-> exp_i_fault)
        else report_error("unexpected fetch fault");
    load_fault_ok: assert property (@(posedge CLK) disable iff (!nRST)
        d_ren && !d_busy |-> d_fault_load == exp_d_fault && !d_fault_store)
        else report_error("load fault outputs differ from the reference");
    store_fault_ok: assert property (@(posedge CLK) disable iff (!nRST)
        d_wen && !d_busy |-> d_fault_store == exp_d_fault && !d_fault_load)
        else report_error("store fault outputs differ from the reference");
    mem_excl_ok: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else report_error("mem_ren and mem_wen high together");
    data_addr_ok: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && !is_table_addr(mem_addr) |->
            mem_addr == exp_d_paddr && !exp_d_fault)
        else report_error("data access at a wrong address or after a fault");
    data_wdata_ok: assert property (@(posedge CLK) disable iff (!nRST)
        mem_wen |-> mem_wdata == exp_d_wdata)
        else report_error("store wrote wrong data");
    load_data_ok: assert property (@(posedge CLK) disable iff (!nRST)
        d_ren && !d_busy && !d_fault_load |-> d_rdata == exp_d_rdata)
        else report_error("load returned wrong data");

    task automatic set_mode(input logic mode, input priv_t p, input logic s);
        @(posedge CLK);
        #2;
        satp_mode = mode;
        priv      = p;
        sum       = s;
    endtask

    task automatic flush_tlbs();
        @(posedge CLK);
        #2 sfence = 1'b1;
        @(posedge CLK);
        #2 sfence = 1'b0;
    endtask

    task automatic fetch_translate(input logic [31:0] va);
        int                  n;
        logic [PA_WIDTH-1:0] pa;
        logic                flt;
        ref_translate(va, INSTRUCTION, pa, flt);
        @(posedge CLK);
        #2;
        exp_i_paddr = pa;
        exp_i_fault = flt;
        i_vaddr     = va;
        i_ren       = 1'b1;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge CLK);
            if (!i_busy)
                break;
        end
        if (n == WAIT_LIMIT) begin
            give_up("fetch translation never finished");
        end else begin
            @(posedge CLK);
            #2 i_ren = 1'b0;
        end
    endtask

    task automatic data_access(input logic [31:0] va, input logic wr, input logic [31:0] wd);
        int                  n;
        logic [PA_WIDTH-1:0] pa;
        logic                flt;
        ref_translate(va, wr ? STORE : LOAD, pa, flt);
        @(posedge CLK);
        #2;
        exp_d_paddr = pa;
        exp_d_fault = flt;
        exp_d_rdata = read_word(pa);
        exp_d_wdata = wd;
        d_vaddr     = va;
        d_wdata     = wd;
        d_wen       = wr;
        d_ren       = !wr;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge CLK);
            if (!d_busy)
                break;
        end
        if (n == WAIT_LIMIT) begin
            give_up("data access never finished");
        end else begin
            @(posedge CLK);
            #2;
            d_ren = 1'b0;
            d_wen = 1'b0;
        end
    endtask

    task automatic check_pte_reads(input int n);
        chk_reads: assert (pte_reads - reads_mark == n)
            else report_error($sformatf("expected %0d PTE reads, saw %0d", n,
                                        pte_reads - reads_mark));
        reads_mark = pte_reads;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        nRST = 1'b0;
        satp_mode = 1'b0;
        satp_ppn = ROOT_PPN;
        priv = M_MODE;
        sum = 1'b0;
        sfence = 1'b0;
        i_ren = 1'b0;
        i_vaddr = 32'h0;
        d_ren = 1'b0;
        d_wen = 1'b0;
        d_vaddr = 32'h0;
        d_wdata = 32'h0;
        exp_i_paddr = '0;
        exp_i_fault = 1'b0;
        exp_d_paddr = '0;
        exp_d_fault = 1'b0;
        exp_d_rdata = 32'h0;
        exp_d_wdata = 32'h0;
        errors = 0;
        err_mark = 0;
        tests = 0;
        failed = 0;
        reads_mark = 0;

        // root and level 0 table start all invalid
        for (int i = 0; i < 1024; i++) begin
            mem[{ROOT_PPN, 10'(i)}] = 32'h0;
            mem[{L0_PPN, 10'(i)}]   = 32'h0;
        end
        mem[{ROOT_PPN, 10'd1}] = {L0_PPN, 10'h001};  // pointer
        mem[{ROOT_PPN, 10'd2}] = {22'h400, 10'h0CF}; // aligned superpage
        mem[{ROOT_PPN, 10'd3}] = {22'h401, 10'h0CF}; // misaligned superpage
        mem[{L0_PPN, 10'd0}]   = {22'h200, 10'h0CF}; // kernel rwx
        mem[{L0_PPN, 10'd1}]   = {22'h201, 10'h043}; // read only
        mem[{L0_PPN, 10'd2}]   = {22'h202, 10'h0DF}; // user rwx
        mem[{L0_PPN, 10'd4}]   = {22'h204, 10'h0CF};

        repeat (10) @(posedge CLK);
        #2 nRST = 1'b1;

        set_mode(1'b0, S_MODE, 1'b0);
        fetch_translate(32'h0000_3000);
        data_access(32'h0000_5008, 1'b0, 32'h0);
        set_mode(1'b1, M_MODE, 1'b0);
        fetch_translate(32'h0040_0010);
        data_access(32'h0000_6004, 1'b1, 32'hCAFE_0001);
        data_access(32'h0000_6004, 1'b0, 32'h0);
        check_pte_reads(0);
        end_test("bare and M mode");

        set_mode(1'b1, S_MODE, 1'b0);
        data_access(32'h0040_0100, 1'b0, 32'h0);
        check_pte_reads(2);
        data_access(32'h0040_0104, 1'b0, 32'h0);
        data_access(32'h0040_0108, 1'b1, 32'h1234_5678);
        data_access(32'h0040_0108, 1'b0, 32'h0);
        check_pte_reads(0);  // all hits
        fetch_translate(32'h0040_0200);
        check_pte_reads(2);
        fetch_translate(32'h0040_0204);
        check_pte_reads(0);
        end_test("sv32 4 KiB pages");

        data_access(32'h0085_3120, 1'b0, 32'h0);
        check_pte_reads(1);
        fetch_translate(32'h0085_3124);
        check_pte_reads(1);
        data_access(32'h00C0_1000, 1'b0, 32'h0);
        fetch_translate(32'h00C0_2000);
        check_pte_reads(2);
        end_test("superpages");

        data_access(32'h0040_1004, 1'b1, 32'h0BAD_0BAD);
        fetch_translate(32'h0040_1000);
        data_access(32'h0040_2000, 1'b0, 32'h0);
        set_mode(1'b1, S_MODE, 1'b1);
        data_access(32'h0040_2000, 1'b0, 32'h0);
        data_access(32'h0040_3000, 1'b0, 32'h0);
        set_mode(1'b1, U_MODE, 1'b0);
        data_access(32'h0040_0100, 1'b0, 32'h0);  // kernel page hit in the TLB
        fetch_translate(32'h0040_2010);
        end_test("permission faults");

        set_mode(1'b1, S_MODE, 1'b0);
        for (int k = 0; k < 2; k++) begin
            flush_tlbs();
            reads_mark = pte_reads;
            fork
                fetch_translate(32'h0040_4010);
                data_access(32'h0085_0040, k[0], 32'h600D_F00D);  // store on the second pass
            join
            check_pte_reads(3);
        end
        end_test("contention and sfence");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- tb.f
mmu_pkg.sv
mem_bus_if.sv
tlb.sv
page_walker.sv
mem_arbiter.sv
mmu_top.sv
tb_mmu.sv

//--- Makefile
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = tb_mmu
FLIST = tb.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
